//--- rtl/replica_pkg.sv
package replica_pkg;

    // ====================
    // Ring and ordering sizes
    // ====================

    // Words per tour ordering, eight cities per word.
    localparam int city_div     = 4;
    localparam int city_div_log = 2;

    // Nodes in the ring. One exchange takes one round per node.
    localparam int node_num = 4;
    localparam int node_log = 2;

    localparam int city_w = 7;

    // The receive FIFO depth doubles as the sender's starting credit count.
    localparam int rx_depth = 4;
    localparam int credit_w = 3;

    // ====================
    // Shared types
    // ====================

    typedef logic [city_w-1:0] city_t;

    // One stored word of an ordering.
    typedef city_t [7:0] replica_data_t;

    // Link format, one byte per city with a zero top bit.
    typedef logic [7:0][7:0] link_word_t;

    typedef struct packed {
        logic       valid;
        logic       last;
        link_word_t data;
    } ring_flit_t;

    // Write request into the ordering store, used by host load and exchange write.
    typedef struct packed {
        logic                    valid;
        logic [city_div_log-1:0] addr;
        replica_data_t           data;
    } store_wr_t;

endpackage

//--- rtl/ordering_ram.sv
`timescale 1ns/1ns

module ordering_ram (
    input  logic                                  clk,
    input  logic                                  reset,

    input  replica_pkg::store_wr_t                load,
    input  replica_pkg::store_wr_t                xwr,

    input  logic                                  rd_en,
    input  logic [replica_pkg::city_div_log-1:0]  rd_addr,
    output logic                                  out_valid,
    output replica_pkg::replica_data_t            out_data,

    input  logic [replica_pkg::city_div_log-1:0]  peek_addr,
    output replica_pkg::replica_data_t            peek_data
);

    replica_pkg::replica_data_t mem [replica_pkg::city_div];

    // The exchange write wins if both sources ever collide.
    always_ff @(posedge clk) begin
        if (xwr.valid) begin
            mem[xwr.addr] <= xwr.data;
        end else if (load.valid) begin
            mem[load.addr] <= load.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_data <= mem[rd_addr];
        end
        peek_data <= mem[peek_addr];
    end

    // Host loads must not overlap an exchange write.
    assert property (@(posedge clk) disable iff (reset) !(load.valid && xwr.valid))
        else $error("ordering_ram: host load and exchange write in the same cycle");

endmodule

//--- rtl/node_reg.sv
`timescale 1ns/1ns

module node_reg (
    input  logic                        clk,
    input  logic                        reset,

    // Words read from the ordering store.
    input  logic                        out_valid,
    input  replica_pkg::replica_data_t  out_data,

    // Outgoing link words toward ring_tx.
    output logic                        tx_valid,
    output replica_pkg::link_word_t     tx_word,
    output logic                        tx_last,
    input  logic                        tx_take,

    // Incoming link words from ring_rx.
    input  logic                        in_valid,
    input  replica_pkg::link_word_t     in_word,
    output logic                        in_take,

    output replica_pkg::store_wr_t      xwr,

    input  logic                        round_start,
    output logic                        round_end,
    output logic                        exchange_last
);

    localparam logic [replica_pkg::city_div_log:0] all_words =
        (replica_pkg::city_div_log + 1)'(replica_pkg::city_div);

    replica_pkg::replica_data_t ord_buf [replica_pkg::city_div];

    logic [replica_pkg::city_div_log:0] cap_cnt;
    logic [replica_pkg::city_div_log:0] sent_cnt;
    logic [replica_pkg::city_div_log:0] in_cnt;
    logic [replica_pkg::city_div_log:0] wr_cnt;
    logic [replica_pkg::node_log-1:0]   round_cnt;
    logic                               round_active;

    replica_pkg::replica_data_t         cur_word;
    replica_pkg::store_wr_t             s1, s2, s3;

    // ====================
    // Outgoing side
    // ====================

    always_ff @(posedge clk) begin
        if (out_valid) begin
            ord_buf[cap_cnt[replica_pkg::city_div_log-1:0]] <= out_data;
        end
    end

    assign cur_word = ord_buf[sent_cnt[replica_pkg::city_div_log-1:0]];
    assign tx_valid = sent_cnt < cap_cnt;
    assign tx_last  = sent_cnt == all_words - 1'b1;

    // Cities go out in reverse order, each padded to a byte.
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            tx_word[i] = {1'b0, cur_word[7-i]};
        end
    end

    // ====================
    // Incoming side
    // ====================

    // A word is only accepted once its slot has been sent, so the store read
    // for that address is long finished.
    assign in_take = round_active && in_valid && (in_cnt < sent_cnt);

    always_ff @(posedge clk) begin
        s1.addr <= in_cnt[replica_pkg::city_div_log-1:0];
        for (int i = 0; i < 8; i++) begin
            s1.data[i] <= in_word[i][replica_pkg::city_w-1:0];
        end
        s2.addr <= s1.addr;
        s2.data <= s1.data;
        s3.addr <= s2.addr;
        s3.data <= s2.data;
        if (reset) begin
            s1.valid <= 1'b0;
            s2.valid <= 1'b0;
            s3.valid <= 1'b0;
        end else begin
            s1.valid <= in_take;
            s2.valid <= s1.valid;
            s3.valid <= s2.valid;
        end
    end

    assign xwr = s3;

    // ====================
    // Word and round counters
    // ====================

    assign round_end     = round_active && (sent_cnt == all_words) && (wr_cnt == all_words);
    assign exchange_last = round_cnt == replica_pkg::node_log'(replica_pkg::node_num - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            cap_cnt      <= '0;
            sent_cnt     <= '0;
            in_cnt       <= '0;
            wr_cnt       <= '0;
            round_cnt    <= '0;
            round_active <= 1'b0;
        end else if (round_start) begin
            cap_cnt      <= '0;
            sent_cnt     <= '0;
            in_cnt       <= '0;
            wr_cnt       <= '0;
            round_active <= 1'b1;
        end else begin
            if (out_valid) cap_cnt <= cap_cnt + 1'b1;
            if (tx_valid && tx_take) sent_cnt <= sent_cnt + 1'b1;
            if (in_take) in_cnt <= in_cnt + 1'b1;
            if (xwr.valid) wr_cnt <= wr_cnt + 1'b1;
            if (round_end) begin
                round_active <= 1'b0;
                round_cnt    <= round_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/exchange_seq.sv
`timescale 1ns/1ns

module exchange_seq (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic                                  exchange_start,
    output logic                                  busy,
    output logic                                  done,

    output logic                                  rd_en,
    output logic [replica_pkg::city_div_log-1:0]  rd_addr,

    output logic                                  round_start,
    input  logic                                  round_end,
    input  logic                                  exchange_last
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_wait,
        st_finish
    } state_t;

    state_t state;

    assign busy        = (state == st_read) || (state == st_wait);
    assign done        = state == st_finish;
    assign rd_en       = state == st_read;
    assign round_start = (state == st_read) && (rd_addr == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            rd_addr <= '0;
        end else begin
            case (state)
                st_idle, st_finish: begin
                    rd_addr <= '0;
                    if (exchange_start) begin
                        state <= st_read;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_read: begin
                    // One store read per cycle, then hand over to node_reg.
                    rd_addr <= rd_addr + 1'b1;
                    if (rd_addr == replica_pkg::city_div_log'(replica_pkg::city_div - 1)) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    rd_addr <= '0;
                    if (round_end) begin
                        state <= exchange_last ? st_finish : st_read;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // node_reg must only close rounds this sequencer opened.
    assert property (@(posedge clk) disable iff (reset) round_end |-> busy)
        else $error("exchange_seq: round_end outside an exchange");

endmodule

//--- rtl/ring_tx.sv
`timescale 1ns/1ns

module ring_tx (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     word_valid,
    input  replica_pkg::link_word_t  word,
    input  logic                     last,
    output logic                     take,

    output replica_pkg::ring_flit_t  tx_flit,
    input  logic                     tx_credit
);

    logic [replica_pkg::credit_w-1:0] credit_cnt;

    // Forward only with a credit in hand.
    assign take = word_valid && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= replica_pkg::credit_w'(replica_pkg::rx_depth);
        end else begin
            credit_cnt <= credit_cnt - replica_pkg::credit_w'(take)
                                     + replica_pkg::credit_w'(tx_credit);
        end
    end

    always_ff @(posedge clk) begin
        tx_flit.last <= last;
        tx_flit.data <= word;
        if (reset) begin
            tx_flit.valid <= 1'b0;
        end else begin
            tx_flit.valid <= take;
        end
    end

    // ====================
    // Credit checks
    // ====================

    // A credit returned above the FIFO depth means the far end miscounted.
    assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= replica_pkg::credit_w'(replica_pkg::rx_depth))
        else $error("ring_tx: credit counter above rx_depth");

endmodule

//--- rtl/ring_rx.sv
`timescale 1ns/1ns

module ring_rx (
    input  logic                     clk,
    input  logic                     reset,

    input  replica_pkg::ring_flit_t  rx_flit,
    output logic                     rx_credit,

    output logic                     word_valid,
    output replica_pkg::link_word_t  word,
    input  logic                     take
);

    // Pointers carry one wrap bit above the FIFO index.
    replica_pkg::link_word_t           fifo [replica_pkg::rx_depth];
    logic [replica_pkg::credit_w-1:0]  wr_ptr;
    logic [replica_pkg::credit_w-1:0]  rd_ptr;
    logic [replica_pkg::credit_w-1:0]  fill;
    logic                              full;
    logic                              pop;

    assign fill       = wr_ptr - rd_ptr;
    assign full       = fill == replica_pkg::credit_w'(replica_pkg::rx_depth);
    assign word_valid = fill != '0;
    assign word       = fifo[rd_ptr[replica_pkg::credit_w-2:0]];
    assign pop        = word_valid && take;

    always_ff @(posedge clk) begin
        if (rx_flit.valid) begin
            fifo[wr_ptr[replica_pkg::credit_w-2:0]] <= rx_flit.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            rx_credit <= 1'b0;
        end else begin
            if (rx_flit.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Each freed slot goes back upstream as one credit.
            rx_credit <= pop;
        end
    end

    // The upstream sender's credits should make overflow impossible.
    assert property (@(posedge clk) disable iff (reset) rx_flit.valid |-> !full)
        else $error("ring_rx: flit pushed into a full FIFO");

endmodule

//--- rtl/exchange_node.sv
`timescale 1ns/1ns

module exchange_node (
    input  logic                                  clk,
    input  logic                                  reset,

    // Host access to the ordering store.
    input  replica_pkg::store_wr_t                load,
    input  logic [replica_pkg::city_div_log-1:0]  peek_addr,
    output replica_pkg::replica_data_t            peek_data,

    input  logic                                  exchange_start,
    output logic                                  exchange_busy,
    output logic                                  exchange_done,

    // Downstream link.
    output replica_pkg::ring_flit_t               tx_flit,
    input  logic                                  tx_credit,

    // Upstream link.
    input  replica_pkg::ring_flit_t               rx_flit,
    output logic                                  rx_credit
);

    replica_pkg::store_wr_t                 xwr;
    logic                                   rd_en;
    logic [replica_pkg::city_div_log-1:0]   rd_addr;
    logic                                   out_valid;
    replica_pkg::replica_data_t             out_data;

    logic                                   round_start;
    logic                                   round_end;
    logic                                   exchange_last;

    logic                                   tx_valid;
    replica_pkg::link_word_t                tx_word;
    logic                                   tx_last;
    logic                                   tx_take;

    logic                                   in_valid;
    replica_pkg::link_word_t                in_word;
    logic                                   in_take;

    ordering_ram ordering_ram0 (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .xwr        (xwr),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .peek_addr  (peek_addr),
        .peek_data  (peek_data)
    );

    exchange_seq exchange_seq0 (
        .clk            (clk),
        .reset          (reset),
        .exchange_start (exchange_start),
        .busy           (exchange_busy),
        .done           (exchange_done),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .round_start    (round_start),
        .round_end      (round_end),
        .exchange_last  (exchange_last)
    );

    node_reg node_reg0 (
        .clk            (clk),
        .reset          (reset),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .tx_valid       (tx_valid),
        .tx_word        (tx_word),
        .tx_last        (tx_last),
        .tx_take        (tx_take),
        .in_valid       (in_valid),
        .in_word        (in_word),
        .in_take        (in_take),
        .xwr            (xwr),
        .round_start    (round_start),
        .round_end      (round_end),
        .exchange_last  (exchange_last)
    );

    ring_tx ring_tx0 (
        .clk        (clk),
        .reset      (reset),
        .word_valid (tx_valid),
        .word       (tx_word),
        .last       (tx_last),
        .take       (tx_take),
        .tx_flit    (tx_flit),
        .tx_credit  (tx_credit)
    );

    ring_rx ring_rx0 (
        .clk        (clk),
        .reset      (reset),
        .rx_flit    (rx_flit),
        .rx_credit  (rx_credit),
        .word_valid (in_valid),
        .word       (in_word),
        .take       (in_take)
    );

endmodule

//--- testbench/tb_exchange_node.sv
`timescale 1ns/1ns

module tb_exchange_node;

    localparam int num_tests       = 5;
    localparam int clk_period      = 4;
    localparam int words_per_ex    = replica_pkg::node_num * replica_pkg::city_div;
    localparam int watchdog_cycles = num_tests * words_per_ex * 40;

    // One row of the stimulus table. Orderings come from a base city and a stride.
    typedef struct packed {
        logic [7:0] load_base;
        logic [7:0] in_base;
        logic [7:0] stride;
        logic [7:0] top_mask;
        logic [7:0] max_delay;
        logic [7:0] send_pct;
    } test_row_t;

    logic                                  clk = 1'b0;
    logic                                  reset;
    replica_pkg::store_wr_t                load;
    logic [replica_pkg::city_div_log-1:0]  peek_addr;
    replica_pkg::replica_data_t            peek_data;
    logic                                  exchange_start;
    logic                                  exchange_busy;
    logic                                  exchange_done;
    replica_pkg::ring_flit_t               tx_flit;
    logic                                  tx_credit = 1'b0;
    replica_pkg::ring_flit_t               rx_flit = '0;
    logic                                  rx_credit;

    test_row_t                tests [num_tests];
    test_row_t                row = '0;
    replica_pkg::ring_flit_t  exp_flits [$];
    replica_pkg::link_word_t  up_words [$];

    int unsigned lcg_state     = 37;
    int          tx_credits    = replica_pkg::rx_depth;
    int          up_credits    = replica_pkg::rx_depth;
    int          owed          = 0;
    int          credit_wait   = 0;
    int          flits_sent    = 0;
    int          credit_pulses = 0;

    always #(clk_period / 2) clk = ~clk;

    exchange_node dut0 (
        .clk            (clk),
        .reset          (reset),
        .load           (load),
        .peek_addr      (peek_addr),
        .peek_data      (peek_data),
        .exchange_start (exchange_start),
        .exchange_busy  (exchange_busy),
        .exchange_done  (exchange_done),
        .tx_flit        (tx_flit),
        .tx_credit      (tx_credit),
        .rx_flit        (rx_flit),
        .rx_credit      (rx_credit)
    );

    // ====================
    // Reference model
    // ====================

    function automatic int unsigned next_rand(int unsigned range);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % range;
    endfunction

    function automatic replica_pkg::replica_data_t make_word(int unsigned base,
            int unsigned ord, int unsigned stride, int unsigned w);
        replica_pkg::replica_data_t d;
        for (int c = 0; c < 8; c++) begin
            d[c] = replica_pkg::city_t'((base + ord * 11 + (w * 8 + c) * stride) % 32);
        end
        return d;
    endfunction

    // Word w of the ordering that the upstream node sends in round r.
    function automatic replica_pkg::link_word_t incoming_word(test_row_t t, int unsigned r,
            int unsigned w);
        replica_pkg::replica_data_t d;
        replica_pkg::link_word_t    lw;
        d = make_word(t.in_base, r + 1, t.stride, w);
        for (int i = 0; i < 8; i++) begin
            lw[i] = {t.top_mask[i], d[i]};
        end
        return lw;
    endfunction

    // Incoming byte i carries city i and its top bit is discarded.
    function automatic replica_pkg::replica_data_t strip_link(replica_pkg::link_word_t lw);
        replica_pkg::replica_data_t d;
        for (int i = 0; i < 8; i++) begin
            d[i] = lw[i][6:0];
        end
        return d;
    endfunction

    // Outgoing byte i carries city 7-i with a zero top bit.
    function automatic replica_pkg::link_word_t to_link(replica_pkg::replica_data_t d);
        replica_pkg::link_word_t lw;
        for (int i = 0; i < 8; i++) begin
            lw[i] = {1'b0, d[7-i]};
        end
        return lw;
    endfunction

    // ====================
    // Checks
    // ====================

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_link(string name, replica_pkg::link_word_t got,
            replica_pkg::link_word_t want);
        if (got !== want) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic check_data(string name, replica_pkg::replica_data_t got,
            replica_pkg::replica_data_t want);
        if (got !== want) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic want);
        if (got !== want) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, want);
            abort_run();
        end
    endtask

    // ====================
    // Ring neighbors
    // ====================

    always @(negedge clk) begin : ring_model
        replica_pkg::ring_flit_t want;
        if (tx_flit.valid) begin
            if (tx_credits == 0) begin
                $display("tx_flit went valid at %0t ns with no link credits left", $time);
                abort_run();
            end
            if (exp_flits.size() == 0) begin
                $display("tx_flit sent an unexpected extra word at %0t ns", $time);
                abort_run();
            end
            want = exp_flits.pop_front();
            check_link("tx_flit.data", tx_flit.data, want.data);
            check_bit("tx_flit.last", tx_flit.last, want.last);
            tx_credits--;
            owed++;
        end
        if (tx_credit) begin
            tx_credits++;
        end
        // The downstream node frees its slots after a random delay.
        tx_credit = 1'b0;
        if (credit_wait > 0) begin
            credit_wait--;
        end else if (owed > 0) begin
            tx_credit   = 1'b1;
            owed--;
            credit_wait = next_rand(row.max_delay + 1);
        end
        if (rx_credit) begin
            up_credits++;
            credit_pulses++;
            if (credit_pulses > flits_sent) begin
                $display("rx_credit pulsed at %0t ns for a flit never sent", $time);
                abort_run();
            end
        end
        rx_flit = '0;
        if (up_words.size() > 0 && up_credits > 0 && next_rand(100) < row.send_pct) begin
            rx_flit.valid = 1'b1;
            rx_flit.last  = (flits_sent % replica_pkg::city_div) == replica_pkg::city_div - 1;
            rx_flit.data  = up_words.pop_front();
            up_credits--;
            flits_sent++;
        end
    end

    // ====================
    // Test sequence
    // ====================

    task automatic peek_check(int unsigned w, replica_pkg::replica_data_t want);
        peek_addr = replica_pkg::city_div_log'(w);
        @(negedge clk);
        check_data("peek_data", peek_data, want);
    endtask

    task automatic load_and_peek(test_row_t t);
        for (int w = 0; w < replica_pkg::city_div; w++) begin
            @(negedge clk);
            load.valid = 1'b1;
            load.addr  = replica_pkg::city_div_log'(w);
            load.data  = make_word(t.load_base, 0, t.stride, w);
        end
        @(negedge clk);
        load.valid = 1'b0;
        for (int w = 0; w < replica_pkg::city_div; w++) begin
            peek_check(w, make_word(t.load_base, 0, t.stride, w));
        end
    endtask

    task automatic prepare_queues(test_row_t t);
        replica_pkg::ring_flit_t    f;
        replica_pkg::replica_data_t d;
        for (int r = 0; r < replica_pkg::node_num; r++) begin
            for (int w = 0; w < replica_pkg::city_div; w++) begin
                // Round r forwards what arrived in round r-1.
                if (r == 0) begin
                    d = make_word(t.load_base, 0, t.stride, w);
                end else begin
                    d = strip_link(incoming_word(t, r - 1, w));
                end
                f.valid = 1'b1;
                f.last  = (w == replica_pkg::city_div - 1);
                f.data  = to_link(d);
                exp_flits.push_back(f);
                up_words.push_back(incoming_word(t, r, w));
            end
        end
    endtask

    task automatic run_exchange();
        int n;
        @(negedge clk);
        check_bit("exchange_busy", exchange_busy, 1'b0);
        exchange_start = 1'b1;
        @(negedge clk);
        exchange_start = 1'b0;
        n = 0;
        while (exchange_done !== 1'b1) begin
            check_bit("exchange_busy", exchange_busy, 1'b1);
            // A second start in the middle of the exchange should change nothing.
            exchange_start = (n == 6);
            n++;
            @(negedge clk);
        end
        exchange_start = 1'b0;
        check_bit("exchange_busy", exchange_busy, 1'b0);
        @(negedge clk);
        check_bit("exchange_done", exchange_done, 1'b0);
        check_bit("exchange_busy", exchange_busy, 1'b0);
    endtask

    task automatic check_counts();
        if (exp_flits.size() != 0 || up_words.size() != 0) begin
            $display("Exchange ended at %0t ns with link words still outstanding", $time);
            abort_run();
        end
        if (credit_pulses != flits_sent || up_credits != replica_pkg::rx_depth) begin
            $display("ERROR at %0t ns: rx_credit pulse count is %0d, expected %0d",
                     $time, credit_pulses, flits_sent);
            abort_run();
        end
    endtask

    initial begin : main
        reset          = 1'b1;
        load           = '0;
        peek_addr      = '0;
        exchange_start = 1'b0;
        tests[0] = '{8'd0,  8'd5,  8'd1, 8'h00, 8'd0,  8'd100};
        tests[1] = '{8'd3,  8'd17, 8'd5, 8'hff, 8'd2,  8'd80};
        tests[2] = '{8'd11, 8'd2,  8'd7, 8'ha5, 8'd12, 8'd100};
        tests[3] = '{8'd20, 8'd29, 8'd3, 8'h3c, 8'd1,  8'd25};
        tests[4] = '{8'd7,  8'd14, 8'd9, 8'h81, 8'd20, 8'd100};
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_bit("exchange_busy", exchange_busy, 1'b0);
        check_bit("exchange_done", exchange_done, 1'b0);
        check_bit("tx_flit.valid", tx_flit.valid, 1'b0);
        check_bit("rx_credit", rx_credit, 1'b0);
        for (int t = 0; t < num_tests; t++) begin
            load_and_peek(tests[t]);
            @(posedge clk);
            row = tests[t];
            prepare_queues(tests[t]);
            run_exchange();
            for (int w = 0; w < replica_pkg::city_div; w++) begin
                peek_check(w, strip_link(incoming_word(tests[t], replica_pkg::node_num - 1, w)));
                check_bit("exchange_done", exchange_done, 1'b0);
            end
            @(posedge clk);
            check_counts();
        end
        $display("=== PASS ===");
        $finish;
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
        abort_run();
    end

endmodule

//--- build.f
rtl/replica_pkg.sv
rtl/ordering_ram.sv
rtl/node_reg.sv
rtl/exchange_seq.sv
rtl/ring_tx.sv
rtl/ring_rx.sv
rtl/exchange_node.sv
testbench/tb_exchange_node.sv

//--- Bender.yml
package:
  name: exchange_node

sources:
  - files:
      - rtl/replica_pkg.sv
      - rtl/ordering_ram.sv
      - rtl/node_reg.sv
      - rtl/exchange_seq.sv
      - rtl/ring_tx.sv
      - rtl/ring_rx.sv
      - rtl/exchange_node.sv
  - target: test
    files:
      - testbench/tb_exchange_node.sv
